//--- logic/pmux_macros.svh
`ifndef PMUX_MACROS_SVH
`define PMUX_MACROS_SVH

// ========================================
// Datapath widths
// ========================================

// Byte address width of the program counter
`define PMUX_PC_BITS 32
// One instruction cache line as delivered by fetch
`define PMUX_LINE_BITS 512
// Every instruction is three 16-bit parcels
`define PMUX_INSN_BITS 48
`define PMUX_INSN_BYTES 6

// ========================================
// Group shape and flow control
// ========================================

// Instructions extracted per fetched group
`define PMUX_SLOTS 4
// Downstream buffer depth, which is also the credit count after reset
`define PMUX_CREDITS 4

// Opcodes live in instruction bits 6:0
`define PMUX_OP_NOP 7'h00
`define PMUX_OP_BSR 7'h20
`define PMUX_OP_JSR 7'h21
`define PMUX_OP_BCC 7'h28
`define PMUX_OP_RET 7'h30

// Target reported when the group holds no flow instruction
`define PMUX_RSTPC 32'hFFFC0000

`endif

//--- logic/pmux_pkg.sv
`default_nettype none

package pmux_pkg;

	`include "pmux_macros.svh"

	// ========================================
	// Plain vector types
	// ========================================

	typedef logic [`PMUX_PC_BITS-1:0] pc_t;
	typedef logic [`PMUX_LINE_BITS-1:0] line_t;
	typedef logic [`PMUX_INSN_BITS-1:0] insn_t;
	// Index of a 16-bit parcel within the line, taken from PC bits 5:1
	typedef logic [4:0] parcel_t;
	// Wide enough to hold zero up to PMUX_CREDITS
	typedef logic [2:0] credit_t;

	// One extracted instruction with its address and validity
	typedef struct packed {
		logic v;
		pc_t pc;
		insn_t insn;
	} slot_t;

	typedef slot_t [`PMUX_SLOTS-1:0] group_t;

	// Per-slot decode of the flow instructions
	typedef struct packed {
		logic is_call;
		logic is_bcc;
		logic is_ret;
		pc_t target;
		pc_t ret_pc;
	} slot_flow_t;

	typedef slot_flow_t [`PMUX_SLOTS-1:0] flow_vec_t;

	// The one flow decision made for a whole group
	typedef struct packed {
		logic do_branch;
		logic do_call;
		logic do_ret;
		pc_t target;
		pc_t ret_pc;
	} flow_result_t;

	// Shift the line so the parcel addressed by the PC lands at bit 0
	// Parcels shifted in from above the line end are NOPs
	function automatic line_t align_line(line_t line, pc_t pc);
		parcel_t idx;
		logic [2*`PMUX_LINE_BITS-1:0] ext;
		idx = pc[5:1];
		ext = {{(`PMUX_LINE_BITS/16){16'(`PMUX_OP_NOP)}}, line};
		ext = ext >> {idx, 4'd0};
		return ext[`PMUX_LINE_BITS-1:0];
	endfunction

	// Address of slot k, which sits k whole instructions past the group PC
	function automatic pc_t slot_pc(pc_t base, int unsigned k);
		return base + pc_t'(k * `PMUX_INSN_BYTES);
	endfunction

endpackage

`default_nettype wire

//--- logic/slot_extractor.sv
`timescale 1ns/1ps
`default_nettype none

`include "pmux_macros.svh"

module slot_extractor (
	input wire logic clk,
	input wire logic rst_i,
	// High on the edge where the group stage takes this group
	input wire logic accept_i,
	input wire pmux_pkg::line_t line_i,
	input wire pmux_pkg::pc_t pc_i,
	input wire logic irq_i,
	input wire logic ssm_i,
	input wire logic branch_miss_i,
	input wire pmux_pkg::pc_t miss_pc_i,
	output pmux_pkg::group_t slots_o
);

	import pmux_pkg::*;

	// ========================================
	// Alignment and slot addresses
	// ========================================

	line_t aligned;
	pc_t [`PMUX_SLOTS-1:0] spc;

	always_comb aligned = align_line(line_i, pc_i);

	always_comb begin
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			spc[k] = slot_pc(pc_i, k);
		end
	end

	// ========================================
	// History of the last accepted group
	// ========================================

	pc_t prev_pc;
	line_t prev_aligned;
	logic prev_ssm;

	// Only accepted groups count as history, so a group offered while
	// credits are exhausted leaves it untouched
	always_ff @(posedge clk) begin
		if (rst_i) begin
			prev_pc <= '0;
			prev_aligned <= '0;
			prev_ssm <= 1'b0;
		end else if (accept_i) begin
			prev_pc <= pc_i;
			prev_aligned <= aligned;
			prev_ssm <= ssm_i;
		end
	end

	// ========================================
	// Slot validity
	// ========================================

	// A group that repeats the previous one exactly would issue twice
	logic redundant;
	// The first group fetched after single step turns on
	logic step_first;
	// Slots that lie before the miss PC belong to the wrong path
	logic [`PMUX_SLOTS-1:0] miss_kill;
	// Slots that the single-step rule lets through
	logic [`PMUX_SLOTS-1:0] step_keep;

	always_comb redundant = (pc_i == prev_pc) && (aligned == prev_aligned);
	always_comb step_first = ssm_i && !prev_ssm;

	always_comb begin
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			miss_kill[k] = branch_miss_i && (miss_pc_i > spc[k]);
			// When stepping, at most slot 0 of the first group survives
			if (ssm_i) begin
				step_keep[k] = (k == 0) && step_first;
			end else begin
				step_keep[k] = 1'b1;
			end
		end
	end

	// Invalid slots still carry their address and raw bits downstream
	always_comb begin
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			slots_o[k].pc = spc[k];
			slots_o[k].insn = aligned[k*`PMUX_INSN_BITS +: `PMUX_INSN_BITS];
			slots_o[k].v = !irq_i && !redundant && !miss_kill[k] && step_keep[k];
		end
	end

endmodule

`default_nettype wire

//--- logic/flow_scanner.sv
`timescale 1ns/1ps
`default_nettype none

`include "pmux_macros.svh"

module flow_scanner (
	input wire pmux_pkg::line_t line_i,
	input wire pmux_pkg::pc_t pc_i,
	output pmux_pkg::flow_vec_t flow_o
);

	import pmux_pkg::*;

	// Field positions inside a 48-bit instruction
	localparam int OP_BITS = 7;
	localparam int DISP_LSB = 24;
	localparam int DISP_BITS = `PMUX_INSN_BITS - DISP_LSB;

	// ========================================
	// Slot contents
	// ========================================

	// Same alignment as the slot extractor so both see identical slots
	line_t aligned;
	insn_t [`PMUX_SLOTS-1:0] insn;
	pc_t [`PMUX_SLOTS-1:0] spc;

	always_comb aligned = align_line(line_i, pc_i);

	always_comb begin
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			insn[k] = aligned[k*`PMUX_INSN_BITS +: `PMUX_INSN_BITS];
			spc[k] = slot_pc(pc_i, k);
		end
	end

	// ========================================
	// Opcode and displacement decode
	// ========================================

	logic [OP_BITS-1:0] opcode [`PMUX_SLOTS];
	pc_t disp [`PMUX_SLOTS];

	always_comb begin
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			opcode[k] = insn[k][OP_BITS-1:0];
			// The displacement is signed and relative to the slot's own PC
			disp[k] = {{(`PMUX_PC_BITS-DISP_BITS){insn[k][`PMUX_INSN_BITS-1]}},
				insn[k][`PMUX_INSN_BITS-1:DISP_LSB]};
		end
	end

	// Every slot is decoded regardless of validity
	// The group stage decides which ones count
	always_comb begin
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			flow_o[k].is_call = (opcode[k] == `PMUX_OP_BSR) || (opcode[k] == `PMUX_OP_JSR);
			flow_o[k].is_bcc = (opcode[k] == `PMUX_OP_BCC);
			flow_o[k].is_ret = (opcode[k] == `PMUX_OP_RET);
			flow_o[k].target = spc[k] + disp[k];
			// A call returns to the instruction right after it
			flow_o[k].ret_pc = spc[k] + pc_t'(`PMUX_INSN_BYTES);
		end
	end

endmodule

`default_nettype wire

//--- logic/group_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "pmux_macros.svh"

module group_stage (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic fetch_valid_i,
	// One pulse per buffer entry freed downstream
	input wire logic credit_return_i,
	input wire pmux_pkg::group_t slots_i,
	input wire pmux_pkg::flow_vec_t flow_i,
	output logic fetch_ready_o,
	output logic accept_o,
	output logic group_valid_o,
	output pmux_pkg::group_t group_o,
	output pmux_pkg::flow_result_t flow_o
);

	import pmux_pkg::*;

	localparam credit_t CREDIT_MAX = credit_t'(`PMUX_CREDITS);

	// ========================================
	// Credit counter
	// ========================================

	credit_t credits;

	// Fetch may only send when a downstream entry is guaranteed free
	always_comb fetch_ready_o = (credits != '0);
	always_comb accept_o = fetch_valid_i && fetch_ready_o;

	// An accept and a return in the same cycle cancel out
	always_ff @(posedge clk) begin
		if (rst_i) begin
			credits <= CREDIT_MAX;
		end else begin
			case ({accept_o, credit_return_i})
				2'b10: credits <= credits - credit_t'(1);
				2'b01: begin
					// A stray return never lifts the count past the buffer depth
					if (credits != CREDIT_MAX) begin
						credits <= credits + credit_t'(1);
					end
				end
				default: credits <= credits;
			endcase
		end
	end

	// ========================================
	// First flow instruction among valid slots
	// ========================================

	flow_result_t pick;

	// Slots are scanned from 0 upward and the first flow instruction wins
	// Whatever follows it in the group is not looked at
	always_comb begin
		logic found;
		found = 1'b0;
		pick.do_branch = 1'b0;
		pick.do_call = 1'b0;
		pick.do_ret = 1'b0;
		pick.target = `PMUX_RSTPC;
		pick.ret_pc = '0;
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			if (!found && slots_i[k].v) begin
				if (flow_i[k].is_call || flow_i[k].is_bcc) begin
					found = 1'b1;
					pick.do_branch = 1'b1;
					pick.target = flow_i[k].target;
					// Only a call pushes a return address
					if (flow_i[k].is_call) begin
						pick.do_call = 1'b1;
						pick.ret_pc = flow_i[k].ret_pc;
					end
				end else if (flow_i[k].is_ret) begin
					found = 1'b1;
					pick.do_ret = 1'b1;
				end
			end
		end
	end

	// ========================================
	// Output register
	// ========================================

	// Valid follows the accept by one cycle and lasts a single cycle
	always_ff @(posedge clk) begin
		if (rst_i) begin
			group_valid_o <= 1'b0;
			flow_o.do_branch <= 1'b0;
			flow_o.do_call <= 1'b0;
			flow_o.do_ret <= 1'b0;
			flow_o.target <= `PMUX_RSTPC;
			flow_o.ret_pc <= '0;
		end else begin
			group_valid_o <= accept_o;
			if (accept_o) begin
				flow_o <= pick;
			end
		end
	end

	// The accepted slots travel on whole, valid or not
	always_ff @(posedge clk) begin
		if (accept_o) begin
			group_o <= slots_i;
		end
	end

endmodule

`default_nettype wire

//--- logic/pipeline_mux.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_mux (
	input wire logic clk,
	input wire logic rst_i,
	// Fetch side
	input wire logic fetch_valid_i,
	input wire pmux_pkg::line_t fetch_line_i,
	input wire pmux_pkg::pc_t fetch_pc_i,
	// Sampled together with the group
	input wire logic irq_i,
	input wire logic ssm_i,
	input wire logic branch_miss_i,
	input wire pmux_pkg::pc_t miss_pc_i,
	// Decode side
	input wire logic credit_return_i,
	output logic fetch_ready_o,
	output logic group_valid_o,
	output pmux_pkg::group_t group_o,
	output pmux_pkg::flow_result_t flow_o
);

	import pmux_pkg::*;

	// Candidate slots and their flow decode, both straight from the fetch inputs
	group_t cand_slots;
	flow_vec_t slot_flow;
	// Tells the extractor to record this group as the previous one
	logic accept;

	// ========================================
	// Combinational extract and scan
	// ========================================

	slot_extractor u_slots (
		.clk(clk),
		.rst_i(rst_i),
		.accept_i(accept),
		.line_i(fetch_line_i),
		.pc_i(fetch_pc_i),
		.irq_i(irq_i),
		.ssm_i(ssm_i),
		.branch_miss_i(branch_miss_i),
		.miss_pc_i(miss_pc_i),
		.slots_o(cand_slots)
	);

	flow_scanner u_flow (
		.line_i(fetch_line_i),
		.pc_i(fetch_pc_i),
		.flow_o(slot_flow)
	);

	// Register stage with call/return priority and credit handling
	group_stage u_group (
		.clk(clk),
		.rst_i(rst_i),
		.fetch_valid_i(fetch_valid_i),
		.credit_return_i(credit_return_i),
		.slots_i(cand_slots),
		.flow_i(slot_flow),
		.fetch_ready_o(fetch_ready_o),
		.accept_o(accept),
		.group_valid_o(group_valid_o),
		.group_o(group_o),
		.flow_o(flow_o)
	);

endmodule

`default_nettype wire

//--- bench/pmux_model.svh
`ifndef PMUX_MODEL_SVH
`define PMUX_MODEL_SVH

// ========================================
// Reference model
// ========================================

// Parcel p of the line, or a NOP parcel once p runs past the line end
function automatic logic [15:0] line_parcel(line_t line, int p);
	if (p < `PMUX_LINE_BITS / 16) begin
		return line[16*p +: 16];
	end
	return 16'h0000;
endfunction

// Rebuild the aligned line parcel by parcel, starting at the PC's parcel
function automatic line_t model_align(line_t line, pc_t pc);
	line_t a;
	for (int p = 0; p < `PMUX_LINE_BITS / 16; p++) begin
		a[16*p +: 16] = line_parcel(line, p + int'(pc[5:1]));
	end
	return a;
endfunction

// Expected slots, judged against the model's own history of accepted groups
function automatic group_t expected_group(line_t line, pc_t pc, logic irq, logic ssm,
	logic miss, pc_t miss_pc);
	group_t g;
	line_t a;
	logic dup;
	pc_t spc;
	a = model_align(line, pc);
	dup = (pc == m_prev_pc) && (a == m_prev_line);
	for (int k = 0; k < `PMUX_SLOTS; k++) begin
		spc = pc + 32'(6 * k);
		g[k].pc = spc;
		g[k].insn = a[48*k +: 48];
		// Stepping lets through slot 0 of the first stepped group only
		g[k].v = !irq && !dup && !(miss && (miss_pc > spc)) &&
			(!ssm || ((k == 0) && !m_prev_ssm));
	end
	return g;
endfunction

// First valid call, branch or return decides the whole group
function automatic flow_result_t expected_flow(group_t g);
	flow_result_t r;
	logic done;
	logic [6:0] op;
	pc_t disp;
	r = '{1'b0, 1'b0, 1'b0, `PMUX_RSTPC, 32'h0};
	done = 1'b0;
	for (int k = 0; k < `PMUX_SLOTS; k++) begin
		op = g[k].insn[6:0];
		disp = {{8{g[k].insn[47]}}, g[k].insn[47:24]};
		if (!done && g[k].v) begin
			if ((op == `PMUX_OP_BSR) || (op == `PMUX_OP_JSR) || (op == `PMUX_OP_BCC)) begin
				done = 1'b1;
				r.do_branch = 1'b1;
				r.target = g[k].pc + disp;
				if (op != `PMUX_OP_BCC) begin
					r.do_call = 1'b1;
					r.ret_pc = g[k].pc + 32'd6;
				end
			end else if (op == `PMUX_OP_RET) begin
				done = 1'b1;
				r.do_ret = 1'b1;
			end
		end
	end
	return r;
endfunction

// ========================================
// Compare tasks
// ========================================

task automatic check_bit(string name, logic got, logic exp);
	if (got !== exp) begin
		$display("MISMATCH %s got %h expected %h", name, got, exp);
		errors++;
	end
endtask

task automatic check_group(string name, group_t got, group_t exp);
	for (int k = 0; k < `PMUX_SLOTS; k++) begin
		if (got[k] !== exp[k]) begin
			$display("MISMATCH %s[%0d] got %h expected %h", name, k, got[k], exp[k]);
			errors++;
		end
	end
endtask

task automatic check_flow(string name, flow_result_t got, flow_result_t exp);
	if (got !== exp) begin
		$display("MISMATCH %s got %h expected %h", name, got, exp);
		errors++;
	end
endtask

`endif

//--- bench/tb_pipeline_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "pmux_macros.svh"

module tb_pipeline_mux;

	import pmux_pkg::*;

	localparam int CLK_NS = 8;
	localparam int IDLE_CYCLES = 2;
	localparam int EXTRACT_CYCLES = 200;
	localparam int INVAL_CYCLES = 200;
	localparam int STEP_ROUNDS = 4;
	localparam int REPEAT_PAIRS = 20;
	localparam int FLOW_CYCLES = 200;
	localparam int CREDIT_CYCLES = 60;
	// Reset, every test loop, the credit prelude and the drain after each test
	localparam int TOTAL_CYCLES = 16 + EXTRACT_CYCLES + INVAL_CYCLES + STEP_ROUNDS * 7 +
		REPEAT_PAIRS * 2 + FLOW_CYCLES + 2 * `PMUX_CREDITS + 4 + CREDIT_CYCLES +
		6 * IDLE_CYCLES;

	logic clk = 1'b0;
	logic rst_i = 1'b1;
	logic fetch_valid_i;
	line_t fetch_line_i;
	pc_t fetch_pc_i;
	logic irq_i;
	logic ssm_i;
	logic branch_miss_i;
	pc_t miss_pc_i;
	logic credit_return_i;
	logic fetch_ready_o;
	logic group_valid_o;
	group_t group_o;
	flow_result_t flow_o;

	// Model history and the scoreboard queues
	pc_t m_prev_pc;
	line_t m_prev_line;
	logic m_prev_ssm;
	int m_credits;
	group_t exp_groups[$];
	flow_result_t exp_flows[$];
	int errors = 0;
	int base_errors = 0;
	int groups_checked = 0;
	int tests_run = 0;

	`include "pmux_model.svh"

	pipeline_mux DUT (
		.clk(clk),
		.rst_i(rst_i),
		.fetch_valid_i(fetch_valid_i),
		.fetch_line_i(fetch_line_i),
		.fetch_pc_i(fetch_pc_i),
		.irq_i(irq_i),
		.ssm_i(ssm_i),
		.branch_miss_i(branch_miss_i),
		.miss_pc_i(miss_pc_i),
		.credit_return_i(credit_return_i),
		.fetch_ready_o(fetch_ready_o),
		.group_valid_o(group_valid_o),
		.group_o(group_o),
		.flow_o(flow_o)
	);

	always #4 clk = ~clk;

	initial begin
		#(TOTAL_CYCLES * 4 * CLK_NS);
		$display("Run timed out after %0d cycles", TOTAL_CYCLES * 4);
		$display("Testbench failed");
		$finish;
	end

	// ========================================
	// Scoreboard
	// ========================================

	// Inputs settle 1 ns after the rising edge, so the falling edge sees
	// exactly what the next rising edge will sample
	always @(negedge clk) begin : scoreboard
		group_t g;
		logic accept;
		if (rst_i) begin
			m_prev_pc = '0;
			m_prev_line = '0;
			m_prev_ssm = 1'b0;
			m_credits = `PMUX_CREDITS;
			exp_groups.delete();
			exp_flows.delete();
		end else begin
			check_bit("fetch_ready_o", fetch_ready_o, m_credits != 0);
			if (group_valid_o === 1'b1) begin
				if (exp_groups.size() == 0) begin
					$display("group_valid_o went high with no group accepted before it");
					errors++;
				end else begin
					check_group("group_o", group_o, exp_groups.pop_front());
					check_flow("flow_o", flow_o, exp_flows.pop_front());
					groups_checked++;
				end
			end else if (exp_groups.size() != 0) begin
				$display("An accepted group did not appear in the following cycle");
				errors++;
				exp_groups.delete();
				exp_flows.delete();
			end
			accept = fetch_valid_i && (m_credits != 0);
			if (accept) begin
				g = expected_group(fetch_line_i, fetch_pc_i, irq_i, ssm_i, branch_miss_i,
					miss_pc_i);
				exp_groups.push_back(g);
				exp_flows.push_back(expected_flow(g));
				m_prev_pc = fetch_pc_i;
				m_prev_line = model_align(fetch_line_i, fetch_pc_i);
				m_prev_ssm = ssm_i;
			end
			if (accept && !credit_return_i) begin
				m_credits--;
			end else if (!accept && credit_return_i && (m_credits < `PMUX_CREDITS)) begin
				m_credits++;
			end
		end
	end

	// ========================================
	// Stimulus helpers
	// ========================================

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	function automatic line_t random_line();
		line_t line;
		for (int i = 0; i < `PMUX_LINE_BITS / 32; i++) begin
			line[32*i +: 32] = $urandom();
		end
		return line;
	endfunction

	function automatic logic [6:0] random_opcode();
		case ($urandom_range(0, 4))
			0: return `PMUX_OP_NOP;
			1: return `PMUX_OP_BSR;
			2: return `PMUX_OP_JSR;
			3: return `PMUX_OP_BCC;
			default: return `PMUX_OP_RET;
		endcase
	endfunction

	// Random line with a flow-relevant opcode planted at each slot position
	function automatic line_t plant_flow_line(pc_t pc);
		line_t line;
		insn_t insn;
		int p;
		line = random_line();
		for (int k = 0; k < `PMUX_SLOTS; k++) begin
			insn = insn_t'({$urandom(), $urandom()});
			insn[6:0] = random_opcode();
			for (int j = 0; j < 3; j++) begin
				p = int'(pc[5:1]) + 3 * k + j;
				if (p < `PMUX_LINE_BITS / 16) begin
					line[16*p +: 16] = insn[16*j +: 16];
				end
			end
		end
		return line;
	endfunction

	task automatic offer_group(line_t line, pc_t pc);
		fetch_valid_i = 1'b1;
		fetch_line_i = line;
		fetch_pc_i = pc;
	endtask

	// Drain the last group, then report this test's error count
	task automatic report_test(string name);
		fetch_valid_i = 1'b0;
		irq_i = 1'b0;
		ssm_i = 1'b0;
		branch_miss_i = 1'b0;
		credit_return_i = 1'b1;
		repeat (IDLE_CYCLES) next_cycle();
		tests_run++;
		$display("%s finished with %0d errors", name, errors - base_errors);
		base_errors = errors;
	endtask

	// ========================================
	// Tests
	// ========================================

	task automatic random_extraction();
		for (int i = 0; i < EXTRACT_CYCLES; i++) begin
			offer_group(random_line(), $urandom());
			fetch_valid_i = ($urandom_range(0, 3) != 0);
			credit_return_i = ($urandom_range(0, 3) != 0);
			next_cycle();
		end
		report_test("extraction");
	endtask

	task automatic sideband_invalidation();
		for (int i = 0; i < INVAL_CYCLES; i++) begin
			offer_group(random_line(), $urandom());
			irq_i = ($urandom_range(0, 3) == 0);
			branch_miss_i = ($urandom_range(0, 1) == 1);
			miss_pc_i = fetch_pc_i + 32'($urandom_range(0, 30));
			credit_return_i = ($urandom_range(0, 3) != 0);
			next_cycle();
		end
		report_test("invalidation");
	endtask

	// Four stepped groups, then three normal ones, in every round
	task automatic single_step_sequence();
		credit_return_i = 1'b1;
		for (int r = 0; r < STEP_ROUNDS; r++) begin
			for (int j = 0; j < 7; j++) begin
				ssm_i = (j < 4);
				offer_group(random_line(), $urandom());
				next_cycle();
			end
		end
		report_test("single_step");
	endtask

	task automatic repeated_groups();
		line_t line;
		pc_t pc;
		credit_return_i = 1'b1;
		for (int i = 0; i < REPEAT_PAIRS; i++) begin
			line = random_line();
			pc = $urandom();
			offer_group(line, pc);
			next_cycle();
			offer_group(line, pc);
			next_cycle();
		end
		report_test("redundancy");
	endtask

	task automatic flow_selection();
		pc_t pc;
		for (int i = 0; i < FLOW_CYCLES; i++) begin
			pc = $urandom();
			offer_group(plant_flow_line(pc), pc);
			irq_i = ($urandom_range(0, 7) == 0);
			branch_miss_i = ($urandom_range(0, 3) == 0);
			miss_pc_i = pc + 32'($urandom_range(0, 24));
			credit_return_i = ($urandom_range(0, 3) != 0);
			next_cycle();
		end
		report_test("flow");
	endtask

	task automatic credit_exhaustion();
		fetch_valid_i = 1'b0;
		credit_return_i = 1'b1;
		repeat (`PMUX_CREDITS) next_cycle();
		// Every return is withheld while fetch keeps offering groups
		credit_return_i = 1'b0;
		for (int i = 0; i < `PMUX_CREDITS + 4; i++) begin
			offer_group(random_line(), $urandom());
			next_cycle();
		end
		check_bit("fetch_ready_o", fetch_ready_o, 1'b0);
		for (int i = 0; i < CREDIT_CYCLES; i++) begin
			offer_group(random_line(), $urandom());
			fetch_valid_i = ($urandom_range(0, 1) == 1);
			credit_return_i = ($urandom_range(0, 2) == 0);
			next_cycle();
		end
		report_test("credits");
	endtask

	initial begin
		void'($urandom(57111));
		fetch_valid_i = 1'b0;
		fetch_line_i = '0;
		fetch_pc_i = '0;
		irq_i = 1'b0;
		ssm_i = 1'b0;
		branch_miss_i = 1'b0;
		miss_pc_i = '0;
		credit_return_i = 1'b0;
		rst_i = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		rst_i = 1'b0;
		check_bit("group_valid_o", group_valid_o, 1'b0);
		check_bit("fetch_ready_o", fetch_ready_o, 1'b1);
		check_flow("flow_o", flow_o, '{1'b0, 1'b0, 1'b0, `PMUX_RSTPC, 32'h0});
		random_extraction();
		sideband_invalidation();
		single_step_sequence();
		repeated_groups();
		flow_selection();
		credit_exhaustion();
		$display("%0d tests, %0d groups checked, %0d errors", tests_run, groups_checked,
			errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+logic
+incdir+bench
logic/pmux_pkg.sv
logic/slot_extractor.sv
logic/flow_scanner.sv
logic/group_stage.sv
logic/pipeline_mux.sv
bench/tb_pipeline_mux.sv

//--- Makefile
# Verilator build and run of the pipeline mux testbench
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f build.f --top-module tb_pipeline_mux -o tb_pipeline_mux

run: compile
	./obj_dir/tb_pipeline_mux | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
